// File: rtl/mips_pkg.sv
// shared types and constants for the MIPS decode stage
// only R-type, lw, sw, beq and addi are known, other opcodes decode as a bubble
// shamt is not carried into execute

package mips_pkg;

	// ========================================
	// widths
	// ========================================
	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int IMM_W      = 16;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;

	// ========================================
	// instruction field positions
	// ========================================
	// lsb of each field, widths above
	localparam int OPCODE_LSB = 26;
	localparam int RS_LSB     = 21;
	localparam int RT_LSB     = 16;
	localparam int RD_LSB     = 11;
	localparam int IMM_LSB    = 0;
	localparam int FUNCT_LSB  = 0;

	// ========================================
	// encodings
	// ========================================
	typedef enum logic [OPCODE_W-1:0] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2B
	} opcode_e;

	// how execute picks the alu function
	typedef enum logic [1:0] {
		ALU_ADD   = 2'b00,
		ALU_SUB   = 2'b01,
		ALU_FUNCT = 2'b10
	} alu_op_e;

	// ========================================
	// ID/EX payload
	// ========================================
	// control bits for ex, mem and wb
	typedef struct packed {
		logic    reg_dst;
		logic    alu_src;
		alu_op_e alu_op;
		logic    branch;
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
		logic    mem_to_reg;
	} id_ex_ctrl_t;

	// data handed to execute
	typedef struct packed {
		logic [DATA_W-1:0]     next_pc;
		logic [DATA_W-1:0]     rs_data;
		logic [DATA_W-1:0]     rt_data;
		logic [DATA_W-1:0]     imm_ext;
		logic [FUNCT_W-1:0]    funct;
		logic [REG_ADDR_W-1:0] rt_addr;
		logic [REG_ADDR_W-1:0] rd_addr;
	} id_ex_data_t;

endpackage

// File: rtl/main_control.sv
// main control decoder, purely combinational
// unknown opcodes give all-zero control, which acts as a bubble downstream
// alu_op only selects the class, execute resolves funct itself

`timescale 1ns/1ps

module main_control (
	input  mips_pkg::opcode_e     i_opcode,
	output mips_pkg::id_ex_ctrl_t o_ctrl
);

	// ========================================
	// decode table
	// ========================================
	always_comb
	begin
		// default is a bubble
		o_ctrl = '0;

		case (i_opcode)
			mips_pkg::OP_RTYPE:
			begin
				o_ctrl.reg_dst   = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.alu_op    = mips_pkg::ALU_FUNCT;
			end

			mips_pkg::OP_LW:
			begin
				// address = rs + imm, result from memory
				o_ctrl.alu_src    = 1'b1;
				o_ctrl.mem_read   = 1'b1;
				o_ctrl.mem_to_reg = 1'b1;
				o_ctrl.reg_write  = 1'b1;
				o_ctrl.alu_op     = mips_pkg::ALU_ADD;
			end

			mips_pkg::OP_SW:
			begin
				o_ctrl.alu_src   = 1'b1;
				o_ctrl.mem_write = 1'b1;
				o_ctrl.alu_op    = mips_pkg::ALU_ADD;
			end

			mips_pkg::OP_BEQ:
			begin
				// compare by subtract, zero flag in execute
				o_ctrl.branch = 1'b1;
				o_ctrl.alu_op = mips_pkg::ALU_SUB;
			end

			mips_pkg::OP_ADDI:
			begin
				o_ctrl.alu_src   = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.alu_op    = mips_pkg::ALU_ADD;
			end

			default:
			begin
				o_ctrl = '0;
			end
		endcase
	end

endmodule

// File: rtl/reg_file.sv
// 32 x 32 register bank, two combinational reads and one write per clock
// register zero always reads zero, writes to it are dropped
// a same-cycle write to a read address is forwarded to that read

`timescale 1ns/1ps

module reg_file (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  logic [mips_pkg::REG_ADDR_W-1:0] i_rs_addr,
	input  logic [mips_pkg::REG_ADDR_W-1:0] i_rt_addr,
	input  logic                            i_we,
	input  logic [mips_pkg::REG_ADDR_W-1:0] i_wr_addr,
	input  logic [mips_pkg::DATA_W-1:0]     i_wr_data,
	output logic [mips_pkg::DATA_W-1:0]     o_rs_data,
	output logic [mips_pkg::DATA_W-1:0]     o_rt_data
);

	logic [mips_pkg::DATA_W-1:0] regs [mips_pkg::NUM_REGS];
	logic                        wr_valid;

	// writes to r0 never land
	assign wr_valid = i_we && (i_wr_addr != '0);

	// ========================================
	// write port
	// ========================================
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			for (int i = 0; i < mips_pkg::NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr_valid)
		begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// ========================================
	// read ports
	// ========================================
	// same rule for both ports
	function automatic logic [mips_pkg::DATA_W-1:0] read_port(
		input logic [mips_pkg::REG_ADDR_W-1:0] addr
	);
		logic [mips_pkg::DATA_W-1:0] value;
		if (addr == '0)
			value = '0;
		else if (wr_valid && (addr == i_wr_addr))
			value = i_wr_data;  // write-through
		else
			value = regs[addr];
		return value;
	endfunction

	assign o_rs_data = read_port(i_rs_addr);
	assign o_rt_data = read_port(i_rt_addr);

endmodule

// File: rtl/id_ex_reg.sv
// ID/EX pipeline register, one cycle of latency
// sign-extends the immediate on the way in
// reset clears control too, so nothing writes memory or registers out of reset

`timescale 1ns/1ps

module id_ex_reg (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  mips_pkg::id_ex_ctrl_t           i_ctrl,
	input  logic [mips_pkg::DATA_W-1:0]     i_next_pc,
	input  logic [mips_pkg::DATA_W-1:0]     i_rs_data,
	input  logic [mips_pkg::DATA_W-1:0]     i_rt_data,
	input  logic [mips_pkg::IMM_W-1:0]      i_imm,
	input  logic [mips_pkg::FUNCT_W-1:0]    i_funct,
	input  logic [mips_pkg::REG_ADDR_W-1:0] i_rt_addr,
	input  logic [mips_pkg::REG_ADDR_W-1:0] i_rd_addr,
	output mips_pkg::id_ex_ctrl_t           o_ctrl,
	output mips_pkg::id_ex_data_t           o_data
);

	localparam int EXT_W = mips_pkg::DATA_W - mips_pkg::IMM_W;

	logic [mips_pkg::DATA_W-1:0] imm_ext;
	mips_pkg::id_ex_data_t       data_next;

	// ========================================
	// sign extension
	// ========================================
	// bit 15 fills the upper half
	assign imm_ext = {{EXT_W{i_imm[mips_pkg::IMM_W-1]}}, i_imm};

	// ========================================
	// payload assembly
	// ========================================
	always_comb
	begin
		data_next.next_pc = i_next_pc;
		data_next.rs_data = i_rs_data;
		data_next.rt_data = i_rt_data;
		data_next.imm_ext = imm_ext;
		data_next.funct   = i_funct;
		// both candidates go on, execute picks with reg_dst
		data_next.rt_addr = i_rt_addr;
		data_next.rd_addr = i_rd_addr;
	end

	// ========================================
	// pipeline register
	// ========================================
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			o_ctrl <= '0;
			o_data <= '0;
		end
		else
		begin
			o_ctrl <= i_ctrl;
			o_data <= data_next;
		end
	end

endmodule

// File: rtl/decode_stage.sv
// MIPS instruction decode stage, no hazard handling or stalls
// every input is sampled each rising edge, results appear one cycle later
// writeback port updates the register bank in the same edge

`timescale 1ns/1ps

module decode_stage (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  logic [mips_pkg::DATA_W-1:0]     i_instr,
	input  logic [mips_pkg::DATA_W-1:0]     i_next_pc,
	input  logic                            i_wb_reg_write,
	input  logic [mips_pkg::REG_ADDR_W-1:0] i_wb_addr,
	input  logic [mips_pkg::DATA_W-1:0]     i_wb_data,
	output mips_pkg::id_ex_ctrl_t           o_ex_ctrl,
	output mips_pkg::id_ex_data_t           o_ex_data
);

	// ========================================
	// instruction fields
	// ========================================
	mips_pkg::opcode_e                opcode;
	logic [mips_pkg::REG_ADDR_W-1:0] rs_addr;
	logic [mips_pkg::REG_ADDR_W-1:0] rt_addr;
	logic [mips_pkg::REG_ADDR_W-1:0] rd_addr;
	logic [mips_pkg::IMM_W-1:0]      imm;
	logic [mips_pkg::FUNCT_W-1:0]    funct;

	mips_pkg::id_ex_ctrl_t           ctrl;
	logic [mips_pkg::DATA_W-1:0]     rs_data;
	logic [mips_pkg::DATA_W-1:0]     rt_data;

	// illegal opcodes are left to the decoder default
	assign opcode  = mips_pkg::opcode_e'(i_instr[mips_pkg::OPCODE_LSB +: mips_pkg::OPCODE_W]);
	assign rs_addr = i_instr[mips_pkg::RS_LSB +: mips_pkg::REG_ADDR_W];
	assign rt_addr = i_instr[mips_pkg::RT_LSB +: mips_pkg::REG_ADDR_W];
	assign rd_addr = i_instr[mips_pkg::RD_LSB +: mips_pkg::REG_ADDR_W];
	assign imm     = i_instr[mips_pkg::IMM_LSB +: mips_pkg::IMM_W];
	assign funct   = i_instr[mips_pkg::FUNCT_LSB +: mips_pkg::FUNCT_W];

	// ========================================
	// submodules
	// ========================================
	main_control main_control_inst (
		.i_opcode (opcode),
		.o_ctrl   (ctrl)
	);

	reg_file reg_file_inst (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_rs_addr (rs_addr),
		.i_rt_addr (rt_addr),
		.i_we      (i_wb_reg_write),
		.i_wr_addr (i_wb_addr),
		.i_wr_data (i_wb_data),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data)
	);

	id_ex_reg id_ex_reg_inst (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_ctrl    (ctrl),
		.i_next_pc (i_next_pc),
		.i_rs_data (rs_data),
		.i_rt_data (rt_data),
		.i_imm     (imm),
		.i_funct   (funct),
		.i_rt_addr (rt_addr),
		.i_rd_addr (rd_addr),
		.o_ctrl    (o_ex_ctrl),
		.o_data    (o_ex_data)
	);

endmodule

// File: verif/decode_stage_asserts.sv
// concurrent checks on the decode stage outputs, bound into decode_stage
// fail_count lets the testbench fold assertion failures into its result

`timescale 1ns/1ps

module decode_stage_asserts (
	input logic                  i_clk,
	input logic                  i_rst_n,
	input mips_pkg::id_ex_ctrl_t o_ex_ctrl
);

	int fail_count = 0;

	// ========================================
	// reset behavior
	// ========================================
	// control is a bubble right after a reset edge
	reset_clears_ctrl: assert property (@(posedge i_clk) !i_rst_n |=> o_ex_ctrl == '0)
	else
	begin
		fail_count++;
		$error("o_ex_ctrl not zero after reset");
	end

	// ========================================
	// control consistency
	// ========================================
	no_read_and_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_ex_ctrl.mem_read && o_ex_ctrl.mem_write))
	else
	begin
		fail_count++;
		$error("mem_read and mem_write both set");
	end

	// rd is only a destination when something is written
	reg_dst_writes: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_ex_ctrl.reg_dst |-> o_ex_ctrl.reg_write)
	else
	begin
		fail_count++;
		$error("reg_dst without reg_write");
	end

	load_uses_mem: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_ex_ctrl.mem_read |-> o_ex_ctrl.mem_to_reg)
	else
	begin
		fail_count++;
		$error("mem_read without mem_to_reg");
	end

endmodule

bind decode_stage decode_stage_asserts decode_stage_asserts_inst (
	.i_clk     (i_clk),
	.i_rst_n   (i_rst_n),
	.o_ex_ctrl (o_ex_ctrl)
);

// File: verif/tb_decode_stage.sv
// testbench for the MIPS decode stage, single clock, no handshake on the DUT
// expected results come from a shadow register bank and the opcode control table
// random stimulus uses a fixed seed, run length is bounded by a cycle limit

`timescale 1ns/1ps

module tb_decode_stage;

	localparam int RESET_CYCLES   = 8;
	localparam int RANDOM_COUNT   = 400;
	localparam int DIRECTED_MAX   = 60;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + RANDOM_COUNT + DIRECTED_MAX + 32;

	logic                  clk;
	logic                  rst_n;
	logic [31:0]           instr;
	logic [31:0]           next_pc;
	logic                  wb_we;
	logic [4:0]            wb_addr;
	logic [31:0]           wb_data;
	mips_pkg::id_ex_ctrl_t ex_ctrl;
	mips_pkg::id_ex_data_t ex_data;

	logic [31:0]           shadow [32];
	mips_pkg::id_ex_ctrl_t exp_ctrl_q [$];
	mips_pkg::id_ex_data_t exp_data_q [$];
	logic                  hold_reset;
	logic [31:0]           pc_cnt;
	int                    error_count;
	int                    check_count;
	int                    cycle_count;

	decode_stage decode_stage_inst (
		.i_clk          (clk),
		.i_rst_n        (rst_n),
		.i_instr        (instr),
		.i_next_pc      (next_pc),
		.i_wb_reg_write (wb_we),
		.i_wb_addr      (wb_addr),
		.i_wb_data      (wb_data),
		.o_ex_ctrl      (ex_ctrl),
		.o_ex_data      (ex_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ========================================
	// reference model
	// ========================================
	function automatic mips_pkg::id_ex_ctrl_t expected_ctrl(input logic [5:0] op);
		mips_pkg::id_ex_ctrl_t c;
		c = '0;
		case (op)
			6'h00:
			begin
				c.reg_dst   = 1'b1;
				c.reg_write = 1'b1;
				c.alu_op    = mips_pkg::ALU_FUNCT;
			end
			6'h23:
			begin
				c.alu_src    = 1'b1;
				c.mem_read   = 1'b1;
				c.mem_to_reg = 1'b1;
				c.reg_write  = 1'b1;
			end
			6'h2B:
			begin
				c.alu_src   = 1'b1;
				c.mem_write = 1'b1;
			end
			6'h04:
			begin
				c.branch = 1'b1;
				c.alu_op = mips_pkg::ALU_SUB;
			end
			6'h08:
			begin
				c.alu_src   = 1'b1;
				c.reg_write = 1'b1;
			end
			default:
			begin
				c = '0;
			end
		endcase
		return c;
	endfunction

	// r0 is zero, a same-cycle write to a nonzero reg is seen by the read
	function automatic logic [31:0] shadow_read(input logic [4:0] ra, input logic we,
		input logic [4:0] wa, input logic [31:0] wd);
		if (ra == 5'd0)
			return 32'h0;
		if (we && (wa == ra))
			return wd;
		return shadow[ra];
	endfunction

	function automatic mips_pkg::id_ex_data_t expected_data(input logic [31:0] ins,
		input logic [31:0] pc, input logic we, input logic [4:0] wa, input logic [31:0] wd);
		mips_pkg::id_ex_data_t d;
		d.next_pc = pc;
		d.rs_data = shadow_read(ins[25:21], we, wa, wd);
		d.rt_data = shadow_read(ins[20:16], we, wa, wd);
		d.imm_ext = {{16{ins[15]}}, ins[15:0]};
		d.funct   = ins[5:0];
		d.rt_addr = ins[20:16];
		d.rd_addr = ins[15:11];
		return d;
	endfunction

	// ========================================
	// compare tasks
	// ========================================
	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			error_count++;
			$display("Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_ctrl(input mips_pkg::id_ex_ctrl_t got, input mips_pkg::id_ex_ctrl_t exp);
		check_count++;
		check_field("ctrl.reg_dst", got.reg_dst, exp.reg_dst);
		check_field("ctrl.alu_src", got.alu_src, exp.alu_src);
		check_field("ctrl.alu_op", got.alu_op, exp.alu_op);
		check_field("ctrl.branch", got.branch, exp.branch);
		check_field("ctrl.mem_read", got.mem_read, exp.mem_read);
		check_field("ctrl.mem_write", got.mem_write, exp.mem_write);
		check_field("ctrl.reg_write", got.reg_write, exp.reg_write);
		check_field("ctrl.mem_to_reg", got.mem_to_reg, exp.mem_to_reg);
	endtask

	task automatic check_data(input mips_pkg::id_ex_data_t got, input mips_pkg::id_ex_data_t exp);
		check_count++;
		check_field("data.next_pc", got.next_pc, exp.next_pc);
		check_field("data.rs_data", got.rs_data, exp.rs_data);
		check_field("data.rt_data", got.rt_data, exp.rt_data);
		check_field("data.imm_ext", got.imm_ext, exp.imm_ext);
		check_field("data.funct", got.funct, exp.funct);
		check_field("data.rt_addr", got.rt_addr, exp.rt_addr);
		check_field("data.rd_addr", got.rd_addr, exp.rd_addr);
	endtask

	// one expected entry per edge, sampled just after the edge
	always @(posedge clk)
	begin
		#1;
		if (exp_ctrl_q.size() > 0)
		begin
			check_ctrl(ex_ctrl, exp_ctrl_q.pop_front());
			check_data(ex_data, exp_data_q.pop_front());
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// ========================================
	// stimulus
	// ========================================
	// drive one instruction and writeback on the falling edge
	task automatic issue(input logic [31:0] ins, input logic we, input logic [4:0] wa,
		input logic [31:0] wd);
		mips_pkg::id_ex_ctrl_t c;
		mips_pkg::id_ex_data_t d;
		@(negedge clk);
		rst_n   = !hold_reset;
		instr   = ins;
		next_pc = pc_cnt;
		wb_we   = we;
		wb_addr = wa;
		wb_data = wd;
		c = '0;
		d = '0;
		if (!hold_reset)
		begin
			c = expected_ctrl(ins[31:26]);
			d = expected_data(ins, pc_cnt, we, wa, wd);
		end
		exp_ctrl_q.push_back(c);
		exp_data_q.push_back(d);
		// shadow follows the bank at the coming edge
		for (int i = 0; i < 32; i++)
		begin
			if (hold_reset)
				shadow[i] = 32'h0;
		end
		if (!hold_reset && we && (wa != 5'd0))
			shadow[wa] = wd;
		pc_cnt = pc_cnt + 32'd4;
	endtask

	function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// mostly legal opcodes, some fully random
	function automatic logic [5:0] pick_opcode();
		logic [5:0] legal [5];
		int         sel;
		legal = '{6'h00, 6'h04, 6'h08, 6'h23, 6'h2B};
		sel = $urandom_range(0, 7);
		if (sel < 5)
			return legal[sel];
		return 6'($urandom_range(0, 63));
	endfunction

	initial
	begin
		logic [31:0] r;
		rst_n       = 1'b0;
		instr       = '0;
		next_pc     = '0;
		wb_we       = 1'b0;
		wb_addr     = '0;
		wb_data     = '0;
		hold_reset  = 1'b1;
		pc_cnt      = 32'h0040_0004;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;
		void'($urandom(74));

		// reset with busy inputs, nothing may come out or land
		for (int i = 0; i < RESET_CYCLES; i++)
			issue(itype(6'h23, 5'd3, 5'd4, 16'h1234), 1'b1, 5'(i + 1), 32'hA5A5_0000 + i);
		hold_reset = 1'b0;

		// every register reads zero after reset
		for (int i = 0; i < 16; i++)
			issue(rtype(5'(2 * i), 5'(2 * i + 1), 5'd0, 6'h20), 1'b0, 5'd0, 32'h0);

		// control table, legal and illegal opcodes
		issue(rtype(5'd1, 5'd2, 5'd3, 6'h22), 1'b0, 5'd0, 32'h0);
		issue(itype(6'h23, 5'd1, 5'd2, 16'h0010), 1'b0, 5'd0, 32'h0);
		issue(itype(6'h2B, 5'd1, 5'd2, 16'h0020), 1'b0, 5'd0, 32'h0);
		issue(itype(6'h04, 5'd1, 5'd2, 16'hFFFC), 1'b0, 5'd0, 32'h0);
		issue(itype(6'h08, 5'd1, 5'd2, 16'h0005), 1'b0, 5'd0, 32'h0);
		issue(itype(6'h02, 5'd7, 5'd8, 16'h1111), 1'b0, 5'd0, 32'h0);
		issue(itype(6'h3F, 5'd9, 5'd10, 16'h2222), 1'b0, 5'd0, 32'h0);
		issue(itype(6'h0D, 5'd11, 5'd12, 16'h3333), 1'b0, 5'd0, 32'h0);
		issue(itype(6'h2A, 5'd13, 5'd14, 16'h4444), 1'b0, 5'd0, 32'h0);

		// writes, then reads of the same regs, r0 stays zero
		issue(rtype(5'd0, 5'd0, 5'd0, 6'h20), 1'b1, 5'd1, 32'h1111_0001);
		issue(rtype(5'd0, 5'd0, 5'd0, 6'h20), 1'b1, 5'd2, 32'h2222_0002);
		issue(rtype(5'd0, 5'd0, 5'd0, 6'h20), 1'b1, 5'd31, 32'hFFFF_001F);
		issue(rtype(5'd0, 5'd0, 5'd0, 6'h20), 1'b1, 5'd0, 32'hDEAD_BEEF);
		issue(rtype(5'd1, 5'd2, 5'd4, 6'h20), 1'b0, 5'd0, 32'h0);
		issue(rtype(5'd31, 5'd0, 5'd5, 6'h25), 1'b0, 5'd0, 32'h0);

		// write-through, and a disabled write that must not forward
		issue(rtype(5'd5, 5'd5, 5'd6, 6'h24), 1'b1, 5'd5, 32'h5555_AAAA);
		issue(rtype(5'd6, 5'd5, 5'd7, 6'h24), 1'b0, 5'd6, 32'h6666_0000);

		// sign extension and field pass-through
		issue(itype(6'h08, 5'd1, 5'd9, 16'h8001), 1'b0, 5'd0, 32'h0);
		issue(itype(6'h08, 5'd2, 5'd9, 16'h7FFF), 1'b0, 5'd0, 32'h0);
		issue(itype(6'h23, 5'd31, 5'd8, 16'hFFFF), 1'b0, 5'd0, 32'h0);
		issue(rtype(5'd1, 5'd31, 5'd31, 6'h2A), 1'b0, 5'd0, 32'h0);

		// random back-to-back traffic
		for (int i = 0; i < RANDOM_COUNT; i++)
		begin
			r      = $urandom();
			pc_cnt = $urandom();
			issue({pick_opcode(), r[25:0]}, 1'($urandom_range(0, 1)), 5'($urandom_range(0, 31)),
				$urandom());
		end

		@(negedge clk);
		wb_we = 1'b0;
		wait (exp_ctrl_q.size() == 0);
		@(negedge clk);
		error_count += decode_stage_inst.decode_stage_asserts_inst.fail_count;
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: sim.f
rtl/mips_pkg.sv
rtl/main_control.sv
rtl/reg_file.sv
rtl/id_ex_reg.sv
rtl/decode_stage.sv
verif/decode_stage_asserts.sv
verif/tb_decode_stage.sv
